// ==== source/uart_link_pkg.sv ====
package uart_link_pkg;

	// serial timing, small for simulation
	localparam int CLKS_PER_BIT = 8;
	localparam int BAUD_CNT_WIDTH = $clog2(CLKS_PER_BIT);
	localparam logic [BAUD_CNT_WIDTH-1:0] BAUD_LAST = BAUD_CNT_WIDTH'(CLKS_PER_BIT - 1);
	localparam logic [BAUD_CNT_WIDTH-1:0] BAUD_HALF = BAUD_CNT_WIDTH'(CLKS_PER_BIT / 2 - 1);

	localparam int BYTE_WIDTH = 8;
	localparam int BIT_CNT_WIDTH = $clog2(BYTE_WIDTH);
	localparam logic [BIT_CNT_WIDTH-1:0] BIT_LAST = BIT_CNT_WIDTH'(BYTE_WIDTH - 1);

	// start + data + stop
	localparam int FRAME_BITS = BYTE_WIDTH + 2;
	localparam int FRAME_CNT_WIDTH = $clog2(FRAME_BITS);
	localparam logic [FRAME_CNT_WIDTH-1:0] FRAME_LAST = FRAME_CNT_WIDTH'(FRAME_BITS - 1);

	localparam int WORD_WIDTH = 32;
	localparam int BYTES_PER_WORD = 4;
	localparam int BYTE_IDX_WIDTH = $clog2(BYTES_PER_WORD);
	localparam logic [BYTE_IDX_WIDTH-1:0] BYTE_IDX_LAST = BYTE_IDX_WIDTH'(BYTES_PER_WORD - 1);

	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
	localparam logic [FIFO_PTR_WIDTH-1:0] FIFO_PTR_LAST = FIFO_PTR_WIDTH'(FIFO_DEPTH - 1);
	localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);
	localparam logic [FIFO_CNT_WIDTH-1:0] FIFO_FULL = FIFO_CNT_WIDTH'(FIFO_DEPTH);

	// alternating pattern on the board LEDs
	localparam logic [BYTE_WIDTH-1:0] LED_RESET = 8'h55;

endpackage

// ==== source/uart_receiver.sv ====
`timescale 1ns/1ps

module uart_receiver (
	input logic CLK,
	input logic reset,
	input logic UART_RX,
	output logic [uart_link_pkg::BYTE_WIDTH-1:0] rx_byte,
	output logic rx_valid
);

	typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP, RX_WAIT} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic [uart_link_pkg::BAUD_CNT_WIDTH-1:0] baud_cnt;
	logic [uart_link_pkg::BIT_CNT_WIDTH-1:0] bit_cnt;
	logic baud_done;

	assign baud_done = (baud_cnt == uart_link_pkg::BAUD_LAST);

	// line idles high
	always_ff @(posedge CLK) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= UART_RX;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= RX_IDLE;
			baud_cnt <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					baud_cnt <= '0;
					if (!rx_sync)
						state <= RX_START;
				end
				// recheck at mid start bit to reject glitches
				RX_START: begin
					if (baud_cnt == uart_link_pkg::BAUD_HALF) begin
						baud_cnt <= '0;
						bit_cnt <= '0;
						state <= rx_sync ? RX_IDLE : RX_DATA;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (baud_done) begin
						baud_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == uart_link_pkg::BIT_LAST)
							state <= RX_STOP;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (baud_done) begin
						baud_cnt <= '0;
						rx_valid <= rx_sync;
						state <= rx_sync ? RX_IDLE : RX_WAIT;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				// framing error, wait for the line to go idle again
				RX_WAIT: begin
					if (rx_sync)
						state <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// lsb arrives first
	always_ff @(posedge CLK) begin
		if (state == RX_DATA && baud_done)
			rx_byte <= {rx_sync, rx_byte[uart_link_pkg::BYTE_WIDTH-1:1]};
	end

	rx_valid_single_pulse: assert property (
		@(posedge CLK) disable iff (reset) rx_valid |=> !rx_valid
	);

endmodule

// ==== source/word_assembler.sv ====
`timescale 1ns/1ps

module word_assembler (
	input logic CLK,
	input logic reset,
	input logic [uart_link_pkg::BYTE_WIDTH-1:0] rx_byte,
	input logic rx_valid,
	output logic [uart_link_pkg::WORD_WIDTH-1:0] asm_word,
	output logic asm_valid,
	input logic asm_ready
);

	logic [uart_link_pkg::WORD_WIDTH-1:0] word_shift;
	logic [uart_link_pkg::BYTE_IDX_WIDTH-1:0] byte_cnt;
	logic word_done;
	logic out_free;

	assign word_done = rx_valid && (byte_cnt == uart_link_pkg::BYTE_IDX_LAST);
	// output register empties on the same edge it is taken
	assign out_free = !asm_valid || asm_ready;

	always_ff @(posedge CLK) begin
		if (reset) begin
			byte_cnt <= '0;
			asm_valid <= 1'b0;
		end else begin
			if (rx_valid)
				byte_cnt <= byte_cnt + 1'b1;
			if (word_done && out_free)
				asm_valid <= 1'b1;
			else if (asm_valid && asm_ready)
				asm_valid <= 1'b0;
		end
	end

	// first byte ends up in the top byte
	always_ff @(posedge CLK) begin
		if (rx_valid)
			word_shift <= {word_shift[uart_link_pkg::WORD_WIDTH-uart_link_pkg::BYTE_WIDTH-1:0],
				rx_byte};
		if (word_done && out_free)
			asm_word <= {word_shift[uart_link_pkg::WORD_WIDTH-uart_link_pkg::BYTE_WIDTH-1:0],
				rx_byte};
	end

	asm_word_held: assert property (
		@(posedge CLK) disable iff (reset)
		asm_valid && !asm_ready |=> asm_valid && $stable(asm_word)
	);

endmodule

// ==== source/word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo (
	input logic CLK,
	input logic reset,
	input logic [uart_link_pkg::WORD_WIDTH-1:0] asm_word,
	input logic asm_valid,
	output logic asm_ready,
	output logic [uart_link_pkg::WORD_WIDTH-1:0] fifo_word,
	output logic fifo_valid,
	input logic fifo_ready
);

	logic [uart_link_pkg::WORD_WIDTH-1:0] mem [uart_link_pkg::FIFO_DEPTH];
	logic [uart_link_pkg::FIFO_PTR_WIDTH-1:0] wr_ptr;
	logic [uart_link_pkg::FIFO_PTR_WIDTH-1:0] rd_ptr;
	logic [uart_link_pkg::FIFO_CNT_WIDTH-1:0] count;
	logic full;
	logic wr_en;
	logic rd_en;

	assign full = (count == uart_link_pkg::FIFO_FULL);
	assign fifo_valid = (count != '0);
	// a full fifo still takes a word when one leaves in the same cycle
	assign asm_ready = !full || fifo_ready;
	assign wr_en = asm_valid && asm_ready;
	assign rd_en = fifo_valid && fifo_ready;
	assign fifo_word = mem[rd_ptr];

	always_ff @(posedge CLK) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == uart_link_pkg::FIFO_PTR_LAST) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == uart_link_pkg::FIFO_PTR_LAST) ? '0 : rd_ptr + 1'b1;
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_en)
			mem[wr_ptr] <= asm_word;
	end

	// occupancy must grow without passing the depth
	no_write_when_full: assert property (
		@(posedge CLK) disable iff (reset)
		wr_en && !rd_en |=> (count > $past(count)) && (count <= uart_link_pkg::FIFO_FULL)
	);

	// a wrap below zero would show up as a larger count
	no_read_when_empty: assert property (
		@(posedge CLK) disable iff (reset)
		rd_en && !wr_en |=> count < $past(count)
	);

endmodule

// ==== source/word_serializer.sv ====
`timescale 1ns/1ps

module word_serializer (
	input logic CLK,
	input logic reset,
	input logic pause,
	input logic [uart_link_pkg::WORD_WIDTH-1:0] fifo_word,
	input logic fifo_valid,
	output logic fifo_ready,
	output logic [uart_link_pkg::BYTE_WIDTH-1:0] tx_byte,
	output logic tx_valid,
	input logic tx_ready,
	output logic [uart_link_pkg::BYTE_WIDTH-1:0] led
);

	logic busy;
	logic [uart_link_pkg::BYTE_IDX_WIDTH-1:0] byte_idx;
	logic [uart_link_pkg::WORD_WIDTH-1:0] hold_word;
	logic take_word;
	logic byte_sent;

	// pause only blocks new words, a word in progress runs to the end
	assign fifo_ready = !busy && !pause;
	assign take_word = fifo_valid && fifo_ready;
	assign tx_valid = busy;
	assign byte_sent = tx_valid && tx_ready;
	assign tx_byte = hold_word[uart_link_pkg::WORD_WIDTH-1 -: uart_link_pkg::BYTE_WIDTH];

	always_ff @(posedge CLK) begin
		if (reset) begin
			busy <= 1'b0;
			byte_idx <= '0;
			led <= uart_link_pkg::LED_RESET;
		end else if (take_word) begin
			busy <= 1'b1;
			byte_idx <= '0;
			led <= fifo_word[uart_link_pkg::WORD_WIDTH-1 -: uart_link_pkg::BYTE_WIDTH];
		end else if (byte_sent) begin
			byte_idx <= byte_idx + 1'b1;
			if (byte_idx == uart_link_pkg::BYTE_IDX_LAST)
				busy <= 1'b0;
		end
	end

	// msb byte first, shift the next one up after each send
	always_ff @(posedge CLK) begin
		if (take_word)
			hold_word <= fifo_word;
		else if (byte_sent)
			hold_word <= hold_word << uart_link_pkg::BYTE_WIDTH;
	end

endmodule

// ==== source/uart_transmitter.sv ====
`timescale 1ns/1ps

module uart_transmitter (
	input logic CLK,
	input logic reset,
	input logic [uart_link_pkg::BYTE_WIDTH-1:0] tx_byte,
	input logic tx_valid,
	output logic tx_ready,
	output logic UART_TX
);

	logic busy;
	logic [uart_link_pkg::BAUD_CNT_WIDTH-1:0] baud_cnt;
	logic [uart_link_pkg::FRAME_CNT_WIDTH-1:0] bit_cnt;
	// data bits with the stop bit above them
	logic [uart_link_pkg::BYTE_WIDTH:0] frame;
	logic start_tx;
	logic baud_done;

	assign tx_ready = !busy;
	assign start_tx = tx_valid && tx_ready;
	assign baud_done = (baud_cnt == uart_link_pkg::BAUD_LAST);

	always_ff @(posedge CLK) begin
		if (reset) begin
			busy <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
			UART_TX <= 1'b1;
		end else if (!busy) begin
			if (tx_valid) begin
				busy <= 1'b1;
				baud_cnt <= '0;
				bit_cnt <= '0;
				UART_TX <= 1'b0;
			end
		end else if (baud_done) begin
			baud_cnt <= '0;
			// stop bit already on the line when the last period ends
			if (bit_cnt == uart_link_pkg::FRAME_LAST) begin
				busy <= 1'b0;
			end else begin
				UART_TX <= frame[0];
				bit_cnt <= bit_cnt + 1'b1;
			end
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (start_tx)
			frame <= {1'b1, tx_byte};
		else if (busy && baud_done)
			frame <= {1'b1, frame[uart_link_pkg::BYTE_WIDTH:1]};
	end

	line_idle_when_ready: assert property (
		@(posedge CLK) disable iff (reset) tx_ready |-> UART_TX
	);

endmodule

// ==== source/uart_word_link.sv ====
`timescale 1ns/1ps

module uart_word_link (
	input logic CLK,
	input logic reset,
	input logic UART_RX,
	input logic pause,
	output logic UART_TX,
	output logic [uart_link_pkg::BYTE_WIDTH-1:0] led
);

	// receive side
	logic [uart_link_pkg::BYTE_WIDTH-1:0] rx_byte;
	logic rx_valid;
	logic [uart_link_pkg::WORD_WIDTH-1:0] asm_word;
	logic asm_valid;
	logic asm_ready;

	// send side
	logic [uart_link_pkg::WORD_WIDTH-1:0] fifo_word;
	logic fifo_valid;
	logic fifo_ready;
	logic [uart_link_pkg::BYTE_WIDTH-1:0] tx_byte;
	logic tx_valid;
	logic tx_ready;

	uart_receiver uart_receiver_inst (
		.CLK(CLK),
		.reset(reset),
		.UART_RX(UART_RX),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid)
	);

	word_assembler word_assembler_inst (
		.CLK(CLK),
		.reset(reset),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.asm_word(asm_word),
		.asm_valid(asm_valid),
		.asm_ready(asm_ready)
	);

	word_fifo word_fifo_inst (
		.CLK(CLK),
		.reset(reset),
		.asm_word(asm_word),
		.asm_valid(asm_valid),
		.asm_ready(asm_ready),
		.fifo_word(fifo_word),
		.fifo_valid(fifo_valid),
		.fifo_ready(fifo_ready)
	);

	word_serializer word_serializer_inst (
		.CLK(CLK),
		.reset(reset),
		.pause(pause),
		.fifo_word(fifo_word),
		.fifo_valid(fifo_valid),
		.fifo_ready(fifo_ready),
		.tx_byte(tx_byte),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.led(led)
	);

	uart_transmitter uart_transmitter_inst (
		.CLK(CLK),
		.reset(reset),
		.tx_byte(tx_byte),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.UART_TX(UART_TX)
	);

endmodule

// ==== sim/tb_uart_word_link.sv ====
`timescale 1ns/1ps

module tb_uart_word_link;

	localparam int BITS = uart_link_pkg::BYTE_WIDTH;
	localparam int WORD = uart_link_pkg::WORD_WIDTH;
	localparam int FRAME_CYCLES = uart_link_pkg::FRAME_BITS * uart_link_pkg::CLKS_PER_BIT;
	localparam int START_TIMEOUT = 40 * FRAME_CYCLES;
	localparam int QUIET_CYCLES = 6 * FRAME_CYCLES;
	localparam int NUM_TESTS = 5;
	localparam int MAX_WORDS = 8;

	logic CLK;
	logic reset;
	logic UART_RX;
	logic pause;
	logic UART_TX;
	logic [BITS-1:0] led;

	// one row per test
	string test_name [NUM_TESTS];
	int send_count [NUM_TESTS];
	bit bad_frame [NUM_TESTS];
	logic [BITS-1:0] bad_byte [NUM_TESTS];
	bit hold_pause [NUM_TESTS];
	int expect_count [NUM_TESTS];
	logic [WORD-1:0] send_words [NUM_TESTS][MAX_WORDS];
	logic [WORD-1:0] expect_words [NUM_TESTS][MAX_WORDS];

	logic [WORD-1:0] got_words [$];
	logic [BITS-1:0] expect_led;
	int error_count;
	int tests_failed;

	uart_word_link uart_word_link_inst (
		.CLK(CLK),
		.reset(reset),
		.UART_RX(UART_RX),
		.pause(pause),
		.UART_TX(UART_TX),
		.led(led)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	task automatic set_row(input int t, input string name, input int count, input bit bad,
			input bit hold);
		test_name[t] = name;
		send_count[t] = count;
		bad_frame[t] = bad;
		bad_byte[t] = BITS'($urandom);
		hold_pause[t] = hold;
	endtask

	task automatic build_table();
		set_row(0, "idle after reset", 0, 1'b0, 1'b0);
		set_row(1, "single word", 1, 1'b0, 1'b0);
		set_row(2, "random stream", 8, 1'b0, 1'b0);
		set_row(3, "bad stop bit", 1, 1'b1, 1'b0);
		set_row(4, "paused consumer", 7, 1'b0, 1'b1);
		for (int t = 0; t < NUM_TESTS; t++)
			for (int w = 0; w < MAX_WORDS; w++)
				send_words[t][w] = $urandom;
		send_words[1][0] = 32'ha1b2c3d4;
		send_words[3][0] = 32'h0f1e2d3c;
		for (int t = 0; t < NUM_TESTS; t++) begin
			// fifo entries plus the word parked in the assembler
			if (hold_pause[t] && send_count[t] > uart_link_pkg::FIFO_DEPTH + 1)
				expect_count[t] = uart_link_pkg::FIFO_DEPTH + 1;
			else
				expect_count[t] = send_count[t];
			for (int w = 0; w < expect_count[t]; w++)
				expect_words[t][w] = send_words[t][w];
		end
	endtask

	// called at posedge + 1 ns, returns at the same phase
	task automatic drive_bit(input logic value);
		UART_RX = value;
		repeat (uart_link_pkg::CLKS_PER_BIT) @(posedge CLK);
		#1;
	endtask

	task automatic send_frame(input logic [BITS-1:0] data, input logic stop_value);
		drive_bit(1'b0);
		for (int i = 0; i < BITS; i++)
			drive_bit(data[i]);
		drive_bit(stop_value);
		// line back to idle after a broken frame
		if (!stop_value)
			drive_bit(1'b1);
	endtask

	task automatic send_stimulus(input int t);
		if (bad_frame[t])
			send_frame(bad_byte[t], 1'b0);
		for (int w = 0; w < send_count[t]; w++)
			for (int b = 0; b < uart_link_pkg::BYTES_PER_WORD; b++)
				send_frame(send_words[t][w][WORD-1-b*BITS -: BITS], 1'b1);
		if (hold_pause[t]) begin
			repeat (uart_link_pkg::CLKS_PER_BIT) @(posedge CLK);
			#1;
			// nothing may leave while paused
			if (led !== expect_led) begin
				$display("mismatch led while paused: expected 0x%02h, got 0x%02h",
					expect_led, led);
				error_count++;
			end
			pause = 1'b0;
		end
	endtask

	task automatic receive_byte(output logic [BITS-1:0] data, output bit ok);
		int waited;
		ok = 1'b0;
		data = '0;
		waited = 0;
		@(negedge CLK);
		while (UART_TX !== 1'b0 && waited < START_TIMEOUT) begin
			@(negedge CLK);
			waited++;
		end
		if (UART_TX !== 1'b0) begin
			$display("timeout: no start bit on UART_TX within %0d cycles", START_TIMEOUT);
			error_count++;
			return;
		end
		// move to mid bit
		repeat (uart_link_pkg::CLKS_PER_BIT / 2) @(negedge CLK);
		if (UART_TX !== 1'b0) begin
			$display("start bit on UART_TX did not last half a bit");
			error_count++;
			return;
		end
		for (int i = 0; i < BITS; i++) begin
			repeat (uart_link_pkg::CLKS_PER_BIT) @(negedge CLK);
			data[i] = UART_TX;
		end
		repeat (uart_link_pkg::CLKS_PER_BIT) @(negedge CLK);
		if (UART_TX !== 1'b1) begin
			$display("mismatch UART_TX stop bit: expected 0x1, got 0x%h", UART_TX);
			error_count++;
		end
		ok = 1'b1;
	endtask

	task automatic receive_words(input int count);
		logic [BITS-1:0] data;
		logic [WORD-1:0] word;
		bit ok;
		ok = 1'b1;
		for (int w = 0; w < count && ok; w++) begin
			word = '0;
			for (int b = 0; b < uart_link_pkg::BYTES_PER_WORD && ok; b++) begin
				receive_byte(data, ok);
				word = {word[WORD-BITS-1:0], data};
			end
			if (ok)
				got_words.push_back(word);
		end
	endtask

	task automatic check_line_idle();
		bit seen;
		seen = 1'b0;
		for (int i = 0; i < QUIET_CYCLES && !seen; i++) begin
			@(negedge CLK);
			if (UART_TX !== 1'b1) begin
				$display("unexpected traffic on UART_TX while the link should be quiet");
				error_count++;
				seen = 1'b1;
			end
		end
	endtask

	task automatic run_test(input int t);
		int errors_before;
		int n;
		errors_before = error_count;
		got_words.delete();
		@(posedge CLK);
		#1;
		pause = hold_pause[t];
		fork
			send_stimulus(t);
			receive_words(expect_count[t]);
		join
		if (got_words.size() != expect_count[t]) begin
			$display("test %0d: expected %0d words back, received %0d", t, expect_count[t],
				got_words.size());
			error_count++;
		end
		n = (got_words.size() < expect_count[t]) ? got_words.size() : expect_count[t];
		for (int w = 0; w < n; w++) begin
			if (got_words[w] !== expect_words[t][w]) begin
				$display("mismatch UART_TX word %0d: expected 0x%08h, got 0x%08h", w,
					expect_words[t][w], got_words[w]);
				error_count++;
			end
		end
		// led shows the top byte of the last word taken
		if (expect_count[t] > 0)
			expect_led = expect_words[t][expect_count[t]-1][WORD-1 -: BITS];
		if (led !== expect_led) begin
			$display("mismatch led: expected 0x%02h, got 0x%02h", expect_led, led);
			error_count++;
		end
		check_line_idle();
		if (error_count != errors_before)
			tests_failed++;
		$display("test %0d %s: %s", t, test_name[t],
			(error_count == errors_before) ? "passed" : "failed");
	endtask

	initial begin
		void'($urandom(32'hdba4));
		reset = 1'b1;
		UART_RX = 1'b1;
		pause = 1'b0;
		error_count = 0;
		tests_failed = 0;
		expect_led = uart_link_pkg::LED_RESET;
		build_table();
		repeat (3) @(posedge CLK);
		#1;
		reset = 1'b0;
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("tests %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, error_count);
		if (error_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== tb.f ====
source/uart_link_pkg.sv
source/uart_receiver.sv
source/word_assembler.sv
source/word_fifo.sv
source/word_serializer.sv
source/uart_transmitter.sv
source/uart_word_link.sv
sim/tb_uart_word_link.sv

// ==== Makefile ====
TOOL := verilator
TOP := tb_uart_word_link
RTL_TOP := uart_word_link
FILE_LIST := tb.f
COMMON_FLAGS := --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only $(COMMON_FLAGS)
SIM_FLAGS := --binary -j 0 $(COMMON_FLAGS)
BUILD_DIR := obj_dir
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
